// File: rtl/mcu_pkg.sv
//////////////////////////////
// Bank size must be a power of two
// Peripheral windows hold word registers only
//////////////////////////////
package mcu_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  localparam int unsigned NUM_BANKS_DEF  = 4;
  localparam int unsigned BANK_WORDS_DEF = 256;

  // Memory map, byte addresses
  localparam logic [ADDR_W-1:0] RAM_START = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] PM_START  = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] FIC_START = 32'h2000_0100;
  localparam logic [ADDR_W-1:0] AO_SPAN   = 32'h0000_0100;

  // Word offset bits inside one peripheral window
  localparam int unsigned AO_OFF_W = $clog2(AO_SPAN / 4);

  localparam int unsigned NUM_FAST_INTR = 15;
  localparam int unsigned PM_INTR_BIT   = 0;
  localparam int unsigned NUM_EXT_INTR  = 14;

  typedef enum logic [1:0] {
    SEL_RAM,
    SEL_PM,
    SEL_FIC,
    SEL_NONE
  } slave_sel_e;

  typedef enum logic [2:0] {
    PM_IDLE,
    PM_ISO_ON,
    PM_SW_OFF,
    PM_WAIT_OFF,
    PM_SW_ON,
    PM_WAIT_ON,
    PM_ISO_OFF
  } pm_state_e;

endpackage

// File: rtl/system_bus.sv
//////////////////////////////
// One request in flight, response two edges after acceptance
// Unmapped addresses answer err with zero data
//////////////////////////////
`timescale 1ns/1ps

module system_bus
  import mcu_pkg::*;
#(
  parameter int unsigned NUM_BANKS  = NUM_BANKS_DEF,
  parameter int unsigned BANK_WORDS = BANK_WORDS_DEF
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             bus_req_valid_i,
  output logic                             bus_req_ready_o,
  input  logic [ADDR_W-1:0]                bus_req_addr_i,
  input  logic                             bus_req_we_i,
  input  logic [DATA_W-1:0]                bus_req_wdata_i,
  output logic                             bus_rsp_valid_o,
  input  logic                             bus_rsp_ready_i,
  output logic [DATA_W-1:0]                bus_rsp_rdata_o,
  output logic                             bus_rsp_err_o,
  output logic [NUM_BANKS-1:0]             bank_sel_o,
  output logic                             pm_sel_o,
  output logic                             fic_sel_o,
  output logic                             slv_we_o,
  output logic [ADDR_W-3:0]                slv_offset_o,
  output logic [DATA_W-1:0]                slv_wdata_o,
  input  logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rdata_i,
  input  logic [NUM_BANKS-1:0]             bank_err_i,
  input  logic [DATA_W-1:0]                pm_rdata_i,
  input  logic [DATA_W-1:0]                fic_rdata_i
);

  localparam int unsigned BANK_AW = $clog2(BANK_WORDS);
  localparam int unsigned IDX_W   = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
  localparam logic [ADDR_W-1:0] RAM_SIZE = ADDR_W'(NUM_BANKS * BANK_WORDS * 4);

  logic [ADDR_W-1:0] ram_rel;
  logic [ADDR_W-1:0] pm_rel;
  logic [ADDR_W-1:0] fic_rel;
  logic [ADDR_W-1:0] dec_rel;
  slave_sel_e        dec_sel;

  logic              req_hs;
  logic              rsp_hs;
  logic              busy_q;
  logic              strobe_q;
  logic              capture_q;
  logic              rsp_valid_q;
  slave_sel_e        sel_q;
  logic [IDX_W-1:0]  bank_q;
  logic              we_q;
  logic [ADDR_W-3:0] offset_q;
  logic [DATA_W-1:0] wdata_q;
  logic [DATA_W-1:0] slv_rdata;
  logic              slv_err;
  logic [DATA_W-1:0] rsp_rdata_q;
  logic              rsp_err_q;

  // Region relative addresses
  assign ram_rel = bus_req_addr_i - RAM_START;
  assign pm_rel  = bus_req_addr_i - PM_START;
  assign fic_rel = bus_req_addr_i - FIC_START;

  always_comb begin
    dec_sel = SEL_NONE;
    dec_rel = '0;
    if (ram_rel < RAM_SIZE) begin
      dec_sel = SEL_RAM;
      dec_rel = ram_rel;
    end else if (pm_rel < AO_SPAN) begin
      dec_sel = SEL_PM;
      dec_rel = pm_rel;
    end else if (fic_rel < AO_SPAN) begin
      dec_sel = SEL_FIC;
      dec_rel = fic_rel;
    end
  end

  assign bus_req_ready_o = !busy_q;
  assign req_hs          = bus_req_valid_i && !busy_q;
  assign rsp_hs          = rsp_valid_q && bus_rsp_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q      <= 1'b0;
      strobe_q    <= 1'b0;
      capture_q   <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      strobe_q  <= req_hs;
      capture_q <= strobe_q;
      if (req_hs) begin
        busy_q <= 1'b1;
      end else if (rsp_hs) begin
        busy_q <= 1'b0;
      end
      if (capture_q) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_hs) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      sel_q    <= dec_sel;
      bank_q   <= dec_rel[BANK_AW+2 +: IDX_W];
      we_q     <= bus_req_we_i;
      offset_q <= dec_rel[ADDR_W-1:2];
      wdata_q  <= bus_req_wdata_i;
    end
    // Writes answer with zero data
    if (capture_q) begin
      rsp_rdata_q <= we_q ? '0 : slv_rdata;
      rsp_err_q   <= slv_err;
    end
  end

  always_comb begin
    slv_rdata = '0;
    slv_err   = 1'b0;
    case (sel_q)
      SEL_RAM: begin
        slv_rdata = bank_rdata_i[bank_q];
        slv_err   = bank_err_i[bank_q];
      end
      SEL_PM:  slv_rdata = pm_rdata_i;
      SEL_FIC: slv_rdata = fic_rdata_i;
      default: slv_err = 1'b1;
    endcase
  end

  always_comb begin
    bank_sel_o = '0;
    if (strobe_q && sel_q == SEL_RAM) begin
      bank_sel_o[bank_q] = 1'b1;
    end
  end

  assign pm_sel_o        = strobe_q && sel_q == SEL_PM;
  assign fic_sel_o       = strobe_q && sel_q == SEL_FIC;
  assign slv_we_o        = we_q;
  assign slv_offset_o    = offset_q;
  assign slv_wdata_o     = wdata_q;
  assign bus_rsp_valid_o = rsp_valid_q;
  assign bus_rsp_rdata_o = rsp_rdata_q;
  assign bus_rsp_err_o   = rsp_err_q;

endmodule

// File: rtl/memory_bank.sv
//////////////////////////////
// Contents survive isolation
// Read data valid one cycle after sel
//////////////////////////////
`timescale 1ns/1ps

module memory_bank
  import mcu_pkg::*;
#(
  parameter int unsigned BANK_WORDS = BANK_WORDS_DEF
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          sel_i,
  input  logic                          we_i,
  input  logic [$clog2(BANK_WORDS)-1:0] offset_i,
  input  logic [DATA_W-1:0]             wdata_i,
  input  logic                          iso_n_i,
  output logic [DATA_W-1:0]             rdata_o,
  output logic                          err_o
);

  logic [DATA_W-1:0] mem_q [BANK_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic              err_q;
  logic              access;

  // Only a powered, released bank takes the access
  assign access = sel_i && iso_n_i;

  always_ff @(posedge clk_i) begin
    if (access && we_i) begin
      mem_q[offset_i] <= wdata_i;
    end
    if (sel_i) begin
      rdata_q <= access ? mem_q[offset_i] : '0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_q <= 1'b0;
    end else if (sel_i) begin
      err_q <= !iso_n_i;
    end
  end

  assign rdata_o = rdata_q;
  assign err_o   = err_q;

endmodule

// File: rtl/fast_intr_ctrl.sv
//////////////////////////////
// Offset 0 enable, offset 1 pending (W1C)
// A line still high keeps its pending bit set
//////////////////////////////
`timescale 1ns/1ps

module fast_intr_ctrl
  import mcu_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     sel_i,
  input  logic                     we_i,
  input  logic [AO_OFF_W-1:0]      offset_i,
  input  logic [DATA_W-1:0]        wdata_i,
  input  logic [NUM_FAST_INTR-1:0] intr_i,
  output logic [DATA_W-1:0]        rdata_o,
  output logic [NUM_FAST_INTR-1:0] irq_o
);

  logic [NUM_FAST_INTR-1:0] enable_q;
  logic [NUM_FAST_INTR-1:0] pending_q;
  logic [NUM_FAST_INTR-1:0] clear;
  logic [DATA_W-1:0]        rdata_q;
  logic                     wr_enable;
  logic                     wr_pending;

  assign wr_enable  = sel_i && we_i && offset_i == AO_OFF_W'(0);
  assign wr_pending = sel_i && we_i && offset_i == AO_OFF_W'(1);
  assign clear      = wr_pending ? wdata_i[NUM_FAST_INTR-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q  <= '0;
      pending_q <= '0;
    end else begin
      if (wr_enable) begin
        enable_q <= wdata_i[NUM_FAST_INTR-1:0];
      end
      // Set wins over clear
      pending_q <= (pending_q & ~clear) | intr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      case (offset_i)
        AO_OFF_W'(0): rdata_q <= DATA_W'(enable_q);
        AO_OFF_W'(1): rdata_q <= DATA_W'(pending_q);
        default:      rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o = rdata_q;
  assign irq_o   = pending_q & enable_q;

endmodule

// File: rtl/power_manager.sv
//////////////////////////////
// Wait states have no timeout, the switch must acknowledge
// Banks are handled one at a time, lowest index first
//////////////////////////////
`timescale 1ns/1ps

module power_manager
  import mcu_pkg::*;
#(
  parameter int unsigned NUM_BANKS = NUM_BANKS_DEF
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 sel_i,
  input  logic                 we_i,
  input  logic [AO_OFF_W-1:0]  offset_i,
  input  logic [DATA_W-1:0]    wdata_i,
  input  logic [NUM_BANKS-1:0] switch_ack_ni,
  output logic [DATA_W-1:0]    rdata_o,
  output logic [NUM_BANKS-1:0] switch_no,
  output logic [NUM_BANKS-1:0] iso_no,
  output logic [NUM_BANKS-1:0] bank_iso_n_o,
  output logic                 done_o
);

  localparam int unsigned IDX_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  pm_state_e              state_q, state_d;
  logic [NUM_BANKS-1:0]   want_q, want_d;
  logic [NUM_BANKS-1:0]   actual_q, actual_d;
  logic [NUM_BANKS-1:0]   switch_n_q, switch_n_d;
  logic [NUM_BANKS-1:0]   iso_n_q, iso_n_d;
  logic [IDX_W-1:0]       cur_q, cur_d;
  logic                   done_q, done_d;
  logic [NUM_BANKS-1:0]   diff;
  logic [IDX_W-1:0]       pick;
  logic                   busy;
  logic [DATA_W-1:0]      rdata_q;

  assign diff = want_q ^ actual_q;
  assign busy = (state_q != PM_IDLE) || (diff != '0);

  // Lowest bank that needs a change
  always_comb begin
    pick = '0;
    for (int i = NUM_BANKS - 1; i >= 0; i--) begin
      if (diff[i]) begin
        pick = IDX_W'(i);
      end
    end
  end

  always_comb begin
    state_d    = state_q;
    want_d     = want_q;
    actual_d   = actual_q;
    switch_n_d = switch_n_q;
    iso_n_d    = iso_n_q;
    cur_d      = cur_q;
    done_d     = 1'b0;
    if (sel_i && we_i && offset_i == AO_OFF_W'(0)) begin
      want_d = wdata_i[NUM_BANKS-1:0];
    end
    case (state_q)
      PM_IDLE: begin
        if (diff != '0) begin
          cur_d   = pick;
          state_d = want_q[pick] ? PM_SW_ON : PM_ISO_ON;
        end
      end
      PM_ISO_ON: begin
        iso_n_d[cur_q] = 1'b0;
        state_d        = PM_SW_OFF;
      end
      PM_SW_OFF: begin
        switch_n_d[cur_q] = 1'b1;
        state_d           = PM_WAIT_OFF;
      end
      PM_WAIT_OFF: begin
        if (switch_ack_ni[cur_q]) begin
          actual_d[cur_q] = 1'b0;
          state_d         = PM_IDLE;
          done_d          = (want_d ^ actual_d) == '0;
        end
      end
      PM_SW_ON: begin
        switch_n_d[cur_q] = 1'b0;
        state_d           = PM_WAIT_ON;
      end
      PM_WAIT_ON: begin
        if (!switch_ack_ni[cur_q]) begin
          state_d = PM_ISO_OFF;
        end
      end
      PM_ISO_OFF: begin
        iso_n_d[cur_q]  = 1'b1;
        actual_d[cur_q] = 1'b1;
        state_d         = PM_IDLE;
        done_d          = (want_d ^ actual_d) == '0;
      end
      default: state_d = PM_IDLE;
    endcase
  end

  // All banks come out of reset powered and released
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= PM_IDLE;
      want_q     <= '1;
      actual_q   <= '1;
      switch_n_q <= '0;
      iso_n_q    <= '1;
      cur_q      <= '0;
      done_q     <= 1'b0;
    end else begin
      state_q    <= state_d;
      want_q     <= want_d;
      actual_q   <= actual_d;
      switch_n_q <= switch_n_d;
      iso_n_q    <= iso_n_d;
      cur_q      <= cur_d;
      done_q     <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      case (offset_i)
        AO_OFF_W'(0): rdata_q <= DATA_W'(actual_q);
        AO_OFF_W'(1): rdata_q <= DATA_W'(busy);
        default:      rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o      = rdata_q;
  assign switch_no    = switch_n_q;
  assign iso_no       = iso_n_q;
  assign bank_iso_n_o = iso_n_q;
  assign done_o       = done_q;

endmodule

// File: rtl/mcu_top.sv
//////////////////////////////
// Single external master, valid/ready on request and response
// Switch acks come from the environment
//////////////////////////////
`timescale 1ns/1ps

module mcu_top
  import mcu_pkg::*;
#(
  parameter int unsigned NUM_BANKS  = NUM_BANKS_DEF,
  parameter int unsigned BANK_WORDS = BANK_WORDS_DEF
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     bus_req_valid_i,
  output logic                     bus_req_ready_o,
  input  logic [ADDR_W-1:0]        bus_req_addr_i,
  input  logic                     bus_req_we_i,
  input  logic [DATA_W-1:0]        bus_req_wdata_i,
  output logic                     bus_rsp_valid_o,
  input  logic                     bus_rsp_ready_i,
  output logic [DATA_W-1:0]        bus_rsp_rdata_o,
  output logic                     bus_rsp_err_o,
  output logic [NUM_BANKS-1:0]     mem_bank_switch_no_o,
  input  logic [NUM_BANKS-1:0]     mem_bank_switch_ack_ni_i,
  output logic [NUM_BANKS-1:0]     mem_bank_iso_no_o,
  input  logic [NUM_EXT_INTR-1:0]  intr_ext_i,
  output logic [NUM_FAST_INTR-1:0] irq_fast_o
);

  localparam int unsigned BANK_AW = $clog2(BANK_WORDS);

  logic [NUM_BANKS-1:0]             bank_sel;
  logic                             pm_sel;
  logic                             fic_sel;
  logic                             slv_we;
  logic [ADDR_W-3:0]                slv_offset;
  logic [DATA_W-1:0]                slv_wdata;
  logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rdata;
  logic [NUM_BANKS-1:0]             bank_err;
  logic [NUM_BANKS-1:0]             bank_iso_n;
  logic [DATA_W-1:0]                pm_rdata;
  logic [DATA_W-1:0]                fic_rdata;
  logic                             pm_done;
  logic [NUM_FAST_INTR-1:0]         fast_intr;

  // PM done on its own line, external sources above it
  assign fast_intr[PM_INTR_BIT]                  = pm_done;
  assign fast_intr[PM_INTR_BIT+1 +: NUM_EXT_INTR] = intr_ext_i;

  system_bus #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) system_bus_i (
    .clk_i,
    .arst_n_i,
    .bus_req_valid_i,
    .bus_req_ready_o,
    .bus_req_addr_i,
    .bus_req_we_i,
    .bus_req_wdata_i,
    .bus_rsp_valid_o,
    .bus_rsp_ready_i,
    .bus_rsp_rdata_o,
    .bus_rsp_err_o,
    .bank_sel_o  (bank_sel),
    .pm_sel_o    (pm_sel),
    .fic_sel_o   (fic_sel),
    .slv_we_o    (slv_we),
    .slv_offset_o(slv_offset),
    .slv_wdata_o (slv_wdata),
    .bank_rdata_i(bank_rdata),
    .bank_err_i  (bank_err),
    .pm_rdata_i  (pm_rdata),
    .fic_rdata_i (fic_rdata)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    memory_bank #(
      .BANK_WORDS(BANK_WORDS)
    ) memory_bank_i (
      .clk_i,
      .arst_n_i,
      .sel_i   (bank_sel[b]),
      .we_i    (slv_we),
      .offset_i(slv_offset[BANK_AW-1:0]),
      .wdata_i (slv_wdata),
      .iso_n_i (bank_iso_n[b]),
      .rdata_o (bank_rdata[b]),
      .err_o   (bank_err[b])
    );
  end

  power_manager #(
    .NUM_BANKS(NUM_BANKS)
  ) power_manager_i (
    .clk_i,
    .arst_n_i,
    .sel_i        (pm_sel),
    .we_i         (slv_we),
    .offset_i     (slv_offset[AO_OFF_W-1:0]),
    .wdata_i      (slv_wdata),
    .switch_ack_ni(mem_bank_switch_ack_ni_i),
    .rdata_o      (pm_rdata),
    .switch_no    (mem_bank_switch_no_o),
    .iso_no       (mem_bank_iso_no_o),
    .bank_iso_n_o (bank_iso_n),
    .done_o       (pm_done)
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .arst_n_i,
    .sel_i   (fic_sel),
    .we_i    (slv_we),
    .offset_i(slv_offset[AO_OFF_W-1:0]),
    .wdata_i (slv_wdata),
    .intr_i  (fast_intr),
    .rdata_o (fic_rdata),
    .irq_o   (irq_fast_o)
  );

endmodule

// File: sim/tb_mcu_tasks.svh
//////////////////////////////
// Included by the testbench top, uses its signals and model state
// Only one bus access runs at a time
//////////////////////////////

task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                           input logic [DATA_W-1:0] exp);
  if (got !== exp) begin
    error_count++;
    stop_run($sformatf("FAILED at %0t: %s got %h, expected %h", $time, what, got, exp));
  end
endtask

// Expected response from the memory map and the model state
function automatic logic [DATA_W-1:0] ref_response(
  input  logic [ADDR_W-1:0] addr,
  input  logic              we,
  input  logic [DATA_W-1:0] wdata,
  output logic              exp_err,
  output logic              known
);
  logic [DATA_W-1:0] result;
  logic [ADDR_W-1:0] off;
  int unsigned       word;
  int unsigned       bank;
  result  = '0;
  exp_err = 1'b0;
  known   = 1'b1;
  if (addr - RAM_START < RAM_WORDS * 4) begin
    word = (addr - RAM_START) >> 2;
    bank = word / BW;
    if (!bank_on_model[bank]) begin
      exp_err = 1'b1;
    end else if (we) begin
      ram_model[word]   = wdata;
      ram_written[word] = 1'b1;
    end else begin
      known  = ram_written[word];
      result = ram_model[word];
    end
  end else if (addr - PM_START < AO_SPAN) begin
    off = (addr - PM_START) >> 2;
    if (we && off == 0) begin
      pm_known = 1'b0;
    end else if (!we && off == 0) begin
      known  = pm_known;
      result = 32'(bank_on_model);
    end else if (!we && off == 1) begin
      // Busy bit is polled and checked by the test itself
      known = 1'b0;
    end
  end else if (addr - FIC_START < AO_SPAN) begin
    off = (addr - FIC_START) >> 2;
    if (we && off == 0) begin
      enable_model = wdata[NUM_FAST_INTR-1:0];
    end else if (!we && off == 0) begin
      result = 32'(enable_model);
    end else if (!we && off == 1) begin
      known = 1'b0;
    end
  end else begin
    exp_err = 1'b1;
  end
  return result;
endfunction

task automatic bus_access(input logic [ADDR_W-1:0] addr, input logic we,
                          input logic [DATA_W-1:0] wdata,
                          output logic [DATA_W-1:0] rdata, output logic err);
  int wait_cnt;
  int hold;
  @(posedge clk_i);
  #1;
  bus_req_valid_i = 1'b1;
  bus_req_addr_i  = addr;
  bus_req_we_i    = we;
  bus_req_wdata_i = wdata;
  wait_cnt = 0;
  @(negedge clk_i);
  while (!bus_req_ready_o) begin
    wait_cnt++;
    if (wait_cnt > TIMEOUT) begin
      stop_run("Timeout: the bus never accepted the request");
    end
    @(negedge clk_i);
  end
  @(posedge clk_i);
  #1;
  bus_req_valid_i = 1'b0;
  wait_cnt = 0;
  @(negedge clk_i);
  while (!bus_rsp_valid_o) begin
    wait_cnt++;
    if (wait_cnt > TIMEOUT) begin
      stop_run("Timeout: no response came back from the bus");
    end
    @(negedge clk_i);
  end
  // Random back-pressure on the response
  hold = {$random(stim_seed)} % 4;
  repeat (hold + 1) @(posedge clk_i);
  #1;
  bus_rsp_ready_i = 1'b1;
  @(negedge clk_i);
  rdata = bus_rsp_rdata_o;
  err   = bus_rsp_err_o;
  @(posedge clk_i);
  #1;
  bus_rsp_ready_i = 1'b0;
endtask

task automatic wait_pm_idle();
  logic [DATA_W-1:0] rdata;
  logic              err;
  int                polls;
  polls = 0;
  rdata = 32'd1;
  while (rdata[0]) begin
    polls++;
    if (polls > TIMEOUT) begin
      stop_run("Timeout: the power manager stayed busy");
    end
    bus_access(PM_START + 32'd4, 1'b0, '0, rdata, err);
  end
endtask

task automatic wait_irq(input int bit_idx);
  int cycles;
  cycles = 0;
  @(negedge clk_i);
  while (!irq_fast_o[bit_idx]) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      stop_run("Timeout: the fast interrupt never came up");
    end
    @(negedge clk_i);
  end
endtask

// File: sim/tb_mcu_top.sv
//////////////////////////////
// Plays the bus master and the bank power switches
// Stops at the first mismatch
//////////////////////////////
`timescale 1ns/1ps

module tb_mcu_top
  import mcu_pkg::*;
();

  localparam int unsigned NB        = NUM_BANKS_DEF;
  localparam int unsigned BW        = BANK_WORDS_DEF;
  localparam int unsigned RAM_WORDS = NB * BW;
  localparam int          TIMEOUT   = 200;

  logic                     clk_i;
  logic                     arst_n_i;
  logic                     bus_req_valid_i;
  logic                     bus_req_ready_o;
  logic [ADDR_W-1:0]        bus_req_addr_i;
  logic                     bus_req_we_i;
  logic [DATA_W-1:0]        bus_req_wdata_i;
  logic                     bus_rsp_valid_o;
  logic                     bus_rsp_ready_i;
  logic [DATA_W-1:0]        bus_rsp_rdata_o;
  logic                     bus_rsp_err_o;
  logic [NB-1:0]            switch_no;
  logic [NB-1:0]            ack_n;
  logic [NB-1:0]            iso_no;
  logic [NUM_EXT_INTR-1:0]  intr_ext_i;
  logic [NUM_FAST_INTR-1:0] irq_fast_o;

  int stim_seed = 32'ha51d;
  int ack_seed  = 32'ha51d;
  int error_count = 0;

  // Reference model state
  logic [DATA_W-1:0]        ram_model [RAM_WORDS];
  logic                     ram_written [RAM_WORDS];
  logic [NB-1:0]            bank_on_model;
  logic                     pm_known;
  logic [NUM_FAST_INTR-1:0] enable_model;
  logic [ADDR_W-1:0]        ram_addrs [$];

  mcu_top #(
    .NUM_BANKS (NB),
    .BANK_WORDS(BW)
  ) dut (
    .clk_i,
    .arst_n_i,
    .bus_req_valid_i,
    .bus_req_ready_o,
    .bus_req_addr_i,
    .bus_req_we_i,
    .bus_req_wdata_i,
    .bus_rsp_valid_o,
    .bus_rsp_ready_i,
    .bus_rsp_rdata_o,
    .bus_rsp_err_o,
    .mem_bank_switch_no_o    (switch_no),
    .mem_bank_switch_ack_ni_i(ack_n),
    .mem_bank_iso_no_o       (iso_no),
    .intr_ext_i,
    .irq_fast_o
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped after an error");
  endtask

  `include "tb_mcu_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Each ack follows its switch 2 to 9 cycles later
  initial begin : switch_ack_model
    int delay_left [NB];
    ack_n = '0;
    for (int b = 0; b < NB; b++) begin
      delay_left[b] = 0;
    end
    forever begin
      @(posedge clk_i);
      #1;
      for (int b = 0; b < NB; b++) begin
        if (delay_left[b] > 0) begin
          delay_left[b]--;
          if (delay_left[b] == 0) begin
            ack_n[b] = switch_no[b];
          end
        end else if (ack_n[b] != switch_no[b]) begin
          delay_left[b] = 2 + {$random(ack_seed)} % 8;
        end
      end
    end
  end

  // A released bank must have its switch closed and acknowledged
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      for (int b = 0; b < NB; b++) begin
        if (iso_no[b]) begin
          check_value("switch while iso released", 32'(switch_no[b]), 0);
          check_value("switch ack while iso released", 32'(ack_n[b]), 0);
        end
      end
    end
  end

  initial begin : response_monitor
    logic [ADDR_W-1:0] acc_addr;
    logic              acc_we;
    logic [DATA_W-1:0] acc_wdata;
    int                acc_cycle;
    int                cycle;
    logic              held;
    logic              prev_valid;
    logic [DATA_W-1:0] held_rdata;
    logic              held_err;
    logic [DATA_W-1:0] exp_rdata;
    logic              exp_err;
    logic              known;
    cycle      = 0;
    acc_cycle  = 0;
    held       = 1'b0;
    prev_valid = 1'b0;
    forever begin
      @(negedge clk_i);
      cycle++;
      if (arst_n_i) begin
        // Valid set by the second edge after acceptance
        if (bus_rsp_valid_o && !prev_valid) begin
          check_value("rsp latency", cycle, acc_cycle + 3);
        end
        if (bus_rsp_valid_o) begin
          check_value("req ready while rsp pending", 32'(bus_req_ready_o), 0);
        end
        if (held) begin
          check_value("held rsp valid", 32'(bus_rsp_valid_o), 1);
          check_value("held rsp rdata", bus_rsp_rdata_o, held_rdata);
          check_value("held rsp err", 32'(bus_rsp_err_o), 32'(held_err));
        end
        held       = bus_rsp_valid_o && !bus_rsp_ready_i;
        held_rdata = bus_rsp_rdata_o;
        held_err   = bus_rsp_err_o;
        if (bus_rsp_valid_o && bus_rsp_ready_i) begin
          exp_rdata = ref_response(acc_addr, acc_we, acc_wdata, exp_err, known);
          check_value("rsp err", 32'(bus_rsp_err_o), 32'(exp_err));
          if (known) begin
            check_value("rsp rdata", bus_rsp_rdata_o, exp_rdata);
          end
        end
        if (bus_req_valid_i && bus_req_ready_o) begin
          acc_addr  = bus_req_addr_i;
          acc_we    = bus_req_we_i;
          acc_wdata = bus_req_wdata_i;
          acc_cycle = cycle;
        end
        prev_valid = bus_rsp_valid_o;
      end
    end
  end

  task automatic ram_test();
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] rdata;
    logic              err;
    for (int b = 0; b < NB; b++) begin
      for (int i = 0; i < 6; i++) begin
        addr = RAM_START + ADDR_W'((b * BW + {$random(stim_seed)} % BW) * 4);
        bus_access(addr, 1'b1, $random(stim_seed), rdata, err);
        ram_addrs.push_back(addr);
      end
    end
    // Overwrite one word so the read shows the last value
    bus_access(ram_addrs[0], 1'b1, 32'hc0de_0001, rdata, err);
    foreach (ram_addrs[i]) begin
      bus_access(ram_addrs[i], 1'b0, '0, rdata, err);
      check_value("ram read err", 32'(err), 0);
    end
  endtask

  task automatic unmapped_test();
    logic [ADDR_W-1:0] bad [4];
    logic [DATA_W-1:0] rdata;
    logic              err;
    bad = '{RAM_START + ADDR_W'(RAM_WORDS * 4), 32'h1000_0000, 32'h2000_0200, 32'hffff_fffc};
    foreach (bad[i]) begin
      bus_access(bad[i], 1'b1, 32'hdead_beef, rdata, err);
      check_value("unmapped write err", 32'(err), 1);
      bus_access(bad[i], 1'b0, '0, rdata, err);
      check_value("unmapped read err", 32'(err), 1);
      check_value("unmapped read data", rdata, 0);
    end
    foreach (ram_addrs[i]) begin
      bus_access(ram_addrs[i], 1'b0, '0, rdata, err);
    end
  endtask

  task automatic power_test(input int bank);
    logic [NB-1:0]     want;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] rdata;
    logic              err;
    want       = '1;
    want[bank] = 1'b0;
    addr       = RAM_START + ADDR_W'((bank * BW + 5) * 4);
    bus_access(PM_START, 1'b1, 32'(want), rdata, err);
    wait_pm_idle();
    check_value("switch ack at power off", 32'(ack_n[bank]), 1);
    check_value("iso at power off", 32'(iso_no[bank]), 0);
    // Contents are lost with the power
    bank_on_model[bank] = 1'b0;
    pm_known            = 1'b1;
    for (int w = bank * BW; w < (bank + 1) * BW; w++) begin
      ram_written[w] = 1'b0;
    end
    bus_access(PM_START, 1'b0, '0, rdata, err);
    bus_access(addr, 1'b1, 32'h1234_5678, rdata, err);
    check_value("write to off bank err", 32'(err), 1);
    bus_access(addr, 1'b0, '0, rdata, err);
    check_value("read from off bank err", 32'(err), 1);
    check_value("read from off bank data", rdata, 0);
    bus_access(PM_START, 1'b1, 32'({NB{1'b1}}), rdata, err);
    wait_pm_idle();
    check_value("switch ack at power on", 32'(ack_n[bank]), 0);
    check_value("iso at power on", 32'(iso_no[bank]), 1);
    bank_on_model[bank] = 1'b1;
    pm_known            = 1'b1;
    bus_access(PM_START, 1'b0, '0, rdata, err);
    bus_access(addr, 1'b1, 32'h8765_4321, rdata, err);
    bus_access(addr, 1'b0, '0, rdata, err);
    check_value("powered bank read err", 32'(err), 0);
  endtask

  initial begin : test_sequence
    logic [DATA_W-1:0]        rdata;
    logic                     err;
    logic [NUM_EXT_INTR-1:0]  pattern;
    logic [NUM_FAST_INTR-1:0] mask;
    arst_n_i        = 1'b0;
    bus_req_valid_i = 1'b0;
    bus_req_addr_i  = '0;
    bus_req_we_i    = 1'b0;
    bus_req_wdata_i = '0;
    bus_rsp_ready_i = 1'b0;
    intr_ext_i      = '0;
    bank_on_model   = '1;
    pm_known        = 1'b1;
    enable_model    = '0;
    for (int w = 0; w < RAM_WORDS; w++) begin
      ram_written[w] = 1'b0;
    end
    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    check_value("rsp valid after reset", 32'(bus_rsp_valid_o), 0);
    check_value("req ready after reset", 32'(bus_req_ready_o), 1);
    check_value("switches after reset", 32'(switch_no), 0);
    check_value("iso after reset", 32'(iso_no), 32'({NB{1'b1}}));
    check_value("irq after reset", 32'(irq_fast_o), 0);

    ram_test();
    unmapped_test();

    // Done pulses stay masked while enable is zero
    power_test(1);
    check_value("irq with enable zero", 32'(irq_fast_o), 0);
    bus_access(FIC_START + 32'd4, 1'b1, 32'(1 << PM_INTR_BIT), rdata, err);
    bus_access(FIC_START + 32'd4, 1'b0, '0, rdata, err);
    check_value("pending after clear", rdata, 0);
    bus_access(FIC_START, 1'b1, 32'(1 << PM_INTR_BIT), rdata, err);
    check_value("irq before power sequence", 32'(irq_fast_o), 0);
    power_test(2);
    wait_irq(PM_INTR_BIT);
    check_value("irq after power sequence", 32'(irq_fast_o), 32'(1 << PM_INTR_BIT));
    bus_access(FIC_START + 32'd4, 1'b1, 32'(1 << PM_INTR_BIT), rdata, err);
    check_value("irq after clear", 32'(irq_fast_o), 0);

    // External lines land one bit above the PM line
    pattern = NUM_EXT_INTR'($random(stim_seed));
    if (pattern == '0) begin
      pattern = 1;
    end
    @(posedge clk_i);
    #1;
    intr_ext_i = pattern;
    @(posedge clk_i);
    #1;
    intr_ext_i = '0;
    bus_access(FIC_START + 32'd4, 1'b0, '0, rdata, err);
    check_value("pending from ext lines", rdata, 32'({pattern, 1'b0}));
    mask = NUM_FAST_INTR'($random(stim_seed));
    bus_access(FIC_START, 1'b1, 32'(mask), rdata, err);
    bus_access(FIC_START, 1'b0, '0, rdata, err);
    check_value("masked irq", 32'(irq_fast_o), 32'({pattern, 1'b0} & mask));
    bus_access(FIC_START + 32'd4, 1'b1, 32'hffff_ffff, rdata, err);
    check_value("irq after clearing all", 32'(irq_fast_o), 0);

    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stop_run("Errors were counted during the run");
    end
  end

endmodule

// File: vlog.f
+incdir+sim
rtl/mcu_pkg.sv
rtl/system_bus.sv
rtl/memory_bank.sv
rtl/fast_intr_ctrl.sv
rtl/power_manager.sv
rtl/mcu_top.sv
sim/tb_mcu_top.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status is nonzero when the simulation stops on $fatal.
cd "$(dirname "$0")" &&
  verilator --binary --timing --top-module tb_mcu_top -f vlog.f \
    -Mdir obj_dir -o tb_mcu_top &&
  ./obj_dir/tb_mcu_top ||
  exit 1
